// ==== Makefile ====
TOP := tagctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vlog.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== testbench/tagctrl_chk.sv ====
`timescale 1ns/1ps

module tagctrl_chk (
  input logic                          clk_i,
  input logic                          reset_i,
  input logic                          rsp_valid_i,
  input logic                          rsp_ready_i,
  input tagctrl_pkg::tagctrl_rsp_t     rsp_i,
  input logic                          mem_req_valid_i,
  input logic                          mem_req_ready_i,
  input tagctrl_pkg::tagctrl_mem_req_t mem_req_i
);

  // A pending response holds until taken
  rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response dropped or changed while stalled");

  // Same rule on the memory request port
  mem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else $error("memory request dropped or changed while stalled");

  // Pipeline comes out of reset empty
  idle_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !rsp_valid_i && !mem_req_valid_i)
    else $error("output valid high right after reset");

endmodule

bind tagctrl_top tagctrl_chk u_chk (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .rsp_valid_i     (rsp_valid_o),
  .rsp_ready_i     (rsp_ready_i),
  .rsp_i           (rsp_o),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_ready_i (mem_req_ready_i),
  .mem_req_i       (mem_req_o)
);

// ==== testbench/tagctrl_tb.sv ====
`timescale 1ns/1ps
`include "tagctrl_params.svh"

module tagctrl_tb;
  localparam int NUM_ROWS = 18;
  localparam int WordW = `TAGCTRL_ADDR_W - $clog2(`TAGCTRL_DATA_W / 8);
  localparam logic [31:0] BASE = `TAGCTRL_DRAM_BASE;
  localparam logic [WordW-1:0] WORD_LO = BASE[31:3];
  localparam logic [31:0] REGION_END = BASE + `TAGCTRL_DRAM_LEN;
  localparam logic [WordW-1:0] WORD_HI = REGION_END[31:3];

  // One stimulus row with its expected response
  typedef struct packed {
    logic                       write;
    logic [`TAGCTRL_ADDR_W-1:0] addr;
    logic [`TAGCTRL_DATA_W-1:0] data;
    logic                       tag;
    logic [`TAGCTRL_DATA_W-1:0] exp_data;
    logic                       exp_tag;
    logic                       exp_err;
  } row_t;

  // Read data waiting in the memory model
  typedef struct packed {
    logic [`TAGCTRL_DATA_W-1:0] data;
    logic [31:0]                due;
  } pend_t;

  logic                          clk_i, reset_i;
  logic                          req_valid_i, req_ready_o;
  tagctrl_pkg::tagctrl_req_t     req_i;
  logic                          rsp_valid_o, rsp_ready_i;
  tagctrl_pkg::tagctrl_rsp_t     rsp_o;
  logic                          mem_req_valid_o, mem_req_ready_i;
  tagctrl_pkg::tagctrl_mem_req_t mem_req_o, mreq;
  logic                          mem_rsp_valid_i;
  tagctrl_pkg::tagctrl_mem_rsp_t mem_rsp_i;

  row_t        rows [NUM_ROWS];
  logic [63:0] mem_words [logic [WordW-1:0]];
  pend_t       pending [$];
  pend_t       pend;
  logic [31:0] cycle;
  logic        req_hs;
  int          drv_idx, chk_idx;

  tagctrl_top dut (.*);

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // Initial memory content, unique per word
  function automatic logic [63:0] fill_word(input logic [31:0] byte_addr);
    logic [WordW-1:0] w;
    w = byte_addr[31:3];
    return {3'h5, w, 3'h3, ~w};
  endfunction

  task automatic set_row(input int idx, input logic wr, input logic [31:0] addr,
                         input logic [63:0] data, input logic tag,
                         input logic [63:0] exp_data, input logic exp_tag, input logic exp_err);
    rows[idx] = '{write: wr, addr: addr, data: data, tag: tag,
                  exp_data: exp_data, exp_tag: exp_tag, exp_err: exp_err};
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin : main
    void'($urandom(65303));
    reset_i = 1'b1;
    // Never written word first, then a capability write and reads of its granule
    set_row(0, 1'b0, BASE + 32'h100, '0, 1'b0, fill_word(BASE + 32'h100), 1'b0, 1'b0);
    set_row(1, 1'b1, BASE, 64'h1111_2222_3333_4444, 1'b1, '0, 1'b0, 1'b0);
    set_row(2, 1'b0, BASE, '0, 1'b0, 64'h1111_2222_3333_4444, 1'b1, 1'b0);
    set_row(3, 1'b1, BASE + 32'h8, 64'h5555_6666_7777_8888, 1'b0, '0, 1'b0, 1'b0);
    set_row(4, 1'b0, BASE, '0, 1'b0, 64'h1111_2222_3333_4444, 1'b0, 1'b0);
    set_row(5, 1'b0, BASE + 32'h8, '0, 1'b0, 64'h5555_6666_7777_8888, 1'b0, 1'b0);
    set_row(6, 1'b1, BASE, 64'h9999_AAAA_BBBB_CCCC, 1'b1, '0, 1'b0, 1'b0);
    // Out of region accesses that would alias tag index 0
    set_row(7, 1'b1, BASE - 32'h8, 64'hDEAD_BEEF_0000_0001, 1'b0, '0, 1'b0, 1'b1);
    set_row(8, 1'b0, REGION_END, '0, 1'b0, '0, 1'b0, 1'b1);
    set_row(9, 1'b1, REGION_END, 64'hDEAD_BEEF_0000_0002, 1'b0, '0, 1'b0, 1'b1);
    set_row(10, 1'b0, BASE, '0, 1'b0, 64'h9999_AAAA_BBBB_CCCC, 1'b1, 1'b0);
    set_row(11, 1'b1, BASE + 32'hFF0, 64'h0123_4567_89AB_CDEF, 1'b1, '0, 1'b0, 1'b0);
    set_row(12, 1'b0, BASE + 32'hFF8, '0, 1'b0, fill_word(BASE + 32'hFF8), 1'b1, 1'b0);
    set_row(13, 1'b0, BASE + 32'hFF0, '0, 1'b0, 64'h0123_4567_89AB_CDEF, 1'b1, 1'b0);
    set_row(14, 1'b1, BASE + 32'h10, 64'hFEDC_BA98_7654_3210, 1'b1, '0, 1'b0, 1'b0);
    set_row(15, 1'b0, BASE + 32'h10, '0, 1'b0, 64'hFEDC_BA98_7654_3210, 1'b1, 1'b0);
    set_row(16, 1'b0, BASE + 32'h18, '0, 1'b0, fill_word(BASE + 32'h18), 1'b1, 1'b0);
    set_row(17, 1'b0, 32'h0, '0, 1'b0, '0, 1'b0, 1'b1);
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
  end

  initial begin : drive_requests
    req_valid_i = 1'b0;
    req_i       = '0;
    wait (!reset_i);
    for (drv_idx = 0; drv_idx < NUM_ROWS; drv_idx++) begin
      req_valid_i = 1'b1;
      req_i.addr  = rows[drv_idx].addr;
      req_i.write = rows[drv_idx].write;
      req_i.wdata = rows[drv_idx].data;
      req_i.tag   = rows[drv_idx].tag;
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
    req_i       = '0;
  end

  // Memory answers reads in order after one to three cycles
  initial begin : memory_model
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    cycle           = '0;
    wait (!reset_i);
    forever begin
      @(negedge clk_i);
      req_hs = mem_req_valid_o && mem_req_ready_i;
      mreq   = mem_req_o;
      @(posedge clk_i);
      #1;
      cycle = cycle + 1;
      if (req_hs) begin
        check_value("memory address in region", 64'(1),
                    64'((mreq.word_addr >= WORD_LO) && (mreq.word_addr < WORD_HI)));
        if (mreq.write) begin
          mem_words[mreq.word_addr] = mreq.wdata;
        end else begin
          pend.data = mem_words.exists(mreq.word_addr) ? mem_words[mreq.word_addr]
                                                       : fill_word({mreq.word_addr, 3'b000});
          pend.due  = cycle + 1 + ($urandom % 3);
          pending.push_back(pend);
        end
      end
      if (pending.size() > 0 && pending[0].due <= cycle) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_i.rdata = pending[0].data;
        void'(pending.pop_front());
      end else begin
        mem_rsp_valid_i = 1'b0;
      end
      mem_req_ready_i = ($urandom % 4) != 0;
    end
  end

  initial begin : check_responses
    rsp_ready_i = 1'b0;
    wait (!reset_i);
    chk_idx = 0;
    while (chk_idx < NUM_ROWS) begin
      @(negedge clk_i);
      if (rsp_valid_o && rsp_ready_i) begin
        check_value($sformatf("row %0d err", chk_idx), 64'(rows[chk_idx].exp_err),
                    64'(rsp_o.err));
        check_value($sformatf("row %0d write", chk_idx), 64'(rows[chk_idx].write),
                    64'(rsp_o.write));
        check_value($sformatf("row %0d tag", chk_idx), 64'(rows[chk_idx].exp_tag),
                    64'(rsp_o.tag));
        check_value($sformatf("row %0d data", chk_idx), rows[chk_idx].exp_data, rsp_o.rdata);
        chk_idx++;
      end
      @(posedge clk_i);
      #1;
      rsp_ready_i = ($urandom % 3) != 0;
    end
    // Every row answered once, nothing may follow
    rsp_ready_i = 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      check_value("no extra response", 64'(0), 64'(rsp_valid_o));
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : watchdog
    repeat (NUM_ROWS * 40 + 3) @(posedge clk_i);
    $display("Timeout: not all responses arrived in time");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verilog/tagctrl_decode.sv ====
`timescale 1ns/1ps
`include "tagctrl_params.svh"

module tagctrl_decode (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_valid_i,
  input  tagctrl_pkg::tagctrl_req_t req_i,
  output logic                      req_ready_o,
  output logic                      desc_valid_o,
  output tagctrl_pkg::tagctrl_desc_t desc_o,
  input  logic                      desc_ready_i
);
  localparam int unsigned AddrW        = `TAGCTRL_ADDR_W;
  localparam int unsigned TagIdxW      = `TAGCTRL_TAG_IDX_W;
  localparam int unsigned GranuleBytes = `TAGCTRL_CAP_SIZE / 8;
  localparam logic [AddrW-1:0] RegionBase = `TAGCTRL_DRAM_BASE;
  localparam logic [AddrW-1:0] RegionLen  = AddrW'(`TAGCTRL_DRAM_LEN);

  tagctrl_pkg::tagctrl_desc_t desc_d, desc_q;
  logic                       valid_q;
  logic [AddrW-1:0]           offset;
  logic                       in_region;

  always_comb begin
    // Below the base the subtraction wraps and fails the length check
    offset    = req_i.addr - RegionBase;
    in_region = (offset < RegionLen);

    desc_d       = '0;
    desc_d.addr  = req_i.addr;
    desc_d.write = req_i.write;
    desc_d.wdata = req_i.wdata;
    desc_d.tag   = req_i.tag;
    desc_d.err   = !in_region;
    if (in_region) begin
      desc_d.tag_idx = TagIdxW'(offset / GranuleBytes);
    end
  end

  // Stage is free when empty or when its content leaves
  assign req_ready_o = !valid_q || desc_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      desc_q <= desc_d;
    end
  end

  assign desc_valid_o = valid_q;
  assign desc_o       = desc_q;

endmodule

// ==== verilog/tagctrl_mem_issue.sv ====
`timescale 1ns/1ps
`include "tagctrl_params.svh"

module tagctrl_mem_issue (
  input  logic                          desc_valid_i,
  input  tagctrl_pkg::tagctrl_desc_t    desc_i,
  output logic                          desc_ready_o,
  output logic                          mem_req_valid_o,
  output tagctrl_pkg::tagctrl_mem_req_t mem_req_o,
  input  logic                          mem_req_ready_i,
  output logic                          fifo_valid_o,
  output tagctrl_pkg::tagctrl_desc_t    fifo_desc_o,
  input  logic                          fifo_ready_i
);
  localparam int unsigned AddrW    = `TAGCTRL_ADDR_W;
  localparam int unsigned WordOffW = $clog2(`TAGCTRL_DATA_W / 8);

  logic needs_mem;
  logic mem_ok;

  // Out-of-region requests skip memory entirely
  assign needs_mem = !desc_i.err;
  assign mem_ok    = !needs_mem || mem_req_ready_i;

  // Memory only sees a request once its descriptor has a slot
  assign mem_req_valid_o = desc_valid_i && needs_mem && fifo_ready_i;

  // Descriptor is queued together with the memory handshake
  assign fifo_valid_o = desc_valid_i && mem_ok;
  assign desc_ready_o = fifo_ready_i && mem_ok;

  always_comb begin
    mem_req_o           = '0;
    mem_req_o.word_addr = desc_i.addr[AddrW-1:WordOffW];
    mem_req_o.write     = desc_i.write;
    mem_req_o.wdata     = desc_i.wdata;
  end

  assign fifo_desc_o = desc_i;

endmodule

// ==== verilog/tagctrl_params.svh ====
`ifndef TAGCTRL_PARAMS_SVH
`define TAGCTRL_PARAMS_SVH

// Bus widths
`define TAGCTRL_ADDR_W 32
`define TAGCTRL_DATA_W 64

// One tag bit guards one capability-sized granule
`define TAGCTRL_CAP_SIZE 128

// Tagged DRAM window
`define TAGCTRL_DRAM_BASE 32'h8000_0000
`define TAGCTRL_DRAM_LEN 4096

// Number of tag bits and the index width to address them
`define TAGCTRL_NUM_TAGS (`TAGCTRL_DRAM_LEN / (`TAGCTRL_CAP_SIZE / 8))
`define TAGCTRL_TAG_IDX_W 8

// Descriptor and read data buffering, also the in-flight limit
`define TAGCTRL_OUTSTANDING 4

`endif

// ==== verilog/tagctrl_pkg.sv ====
`include "tagctrl_params.svh"

package tagctrl_pkg;

  // Request from the CPU port
  typedef struct packed {
    logic [`TAGCTRL_ADDR_W-1:0] addr;
    logic                       write;
    logic [`TAGCTRL_DATA_W-1:0] wdata;
    logic                       tag;
  } tagctrl_req_t;

  // Descriptor that follows a request down the pipeline
  typedef struct packed {
    logic [`TAGCTRL_ADDR_W-1:0]    addr;
    logic                          write;
    logic [`TAGCTRL_DATA_W-1:0]    wdata;
    logic                          tag;         // tag bit sent with a write
    logic [`TAGCTRL_TAG_IDX_W-1:0] tag_idx;
    logic                          err;         // address outside the DRAM window
    logic                          stored_tag;  // tag bit read from the store
  } tagctrl_desc_t;

  // Word-addressed request toward memory
  typedef struct packed {
    logic [`TAGCTRL_ADDR_W-$clog2(`TAGCTRL_DATA_W/8)-1:0] word_addr;
    logic                                                 write;
    logic [`TAGCTRL_DATA_W-1:0]                           wdata;
  } tagctrl_mem_req_t;

  // Read data from memory
  typedef struct packed {
    logic [`TAGCTRL_DATA_W-1:0] rdata;
  } tagctrl_mem_rsp_t;

  // Response to the CPU port
  typedef struct packed {
    logic [`TAGCTRL_DATA_W-1:0] rdata;
    logic                       tag;
    logic                       write;
    logic                       err;
  } tagctrl_rsp_t;

endpackage

// ==== verilog/tagctrl_resp_merge.sv ====
`timescale 1ns/1ps

module tagctrl_resp_merge (
  input  logic                          desc_valid_i,
  input  tagctrl_pkg::tagctrl_desc_t    desc_i,
  output logic                          desc_ready_o,
  input  logic                          mem_valid_i,
  input  tagctrl_pkg::tagctrl_mem_rsp_t mem_i,
  output logic                          mem_ready_o,
  output logic                          rsp_valid_o,
  output tagctrl_pkg::tagctrl_rsp_t     rsp_o,
  input  logic                          rsp_ready_i
);
  logic is_read;
  logic done;

  // Only in-region reads wait for memory data
  assign is_read = !desc_i.write && !desc_i.err;

  assign rsp_valid_o = desc_valid_i && (!is_read || mem_valid_i);
  assign done        = rsp_valid_o && rsp_ready_i;

  // Both heads retire in the same cycle for a read
  assign desc_ready_o = done;
  assign mem_ready_o  = done && is_read;

  always_comb begin
    rsp_o       = '0;
    rsp_o.write = desc_i.write;
    rsp_o.err   = desc_i.err;
    if (is_read) begin
      rsp_o.rdata = mem_i.rdata;
      rsp_o.tag   = desc_i.stored_tag;
    end
  end

endmodule

// ==== verilog/tagctrl_stream_fifo.sv ====
`timescale 1ns/1ps
`include "tagctrl_params.svh"

module tagctrl_stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = `TAGCTRL_OUTSTANDING
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrW-1:0]     wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]     count_q;
  logic                empty, push, pop;

  assign empty   = (count_q == '0);
  assign ready_o = (count_q != CntW'(Depth));

  // Empty buffer hands the input straight through
  assign valid_o = !empty || valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // Store only what is not consumed in the same cycle
  assign push = valid_i && ready_o && !(empty && ready_i);
  assign pop  = !empty && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== verilog/tagctrl_tag_store.sv ====
`timescale 1ns/1ps
`include "tagctrl_params.svh"

module tagctrl_tag_store (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       desc_valid_i,
  input  tagctrl_pkg::tagctrl_desc_t desc_i,
  output logic                       desc_ready_o,
  output logic                       desc_valid_o,
  output tagctrl_pkg::tagctrl_desc_t desc_o,
  input  logic                       desc_ready_i
);
  localparam int unsigned NumTags = `TAGCTRL_NUM_TAGS;

  logic [NumTags-1:0]         tags_q;
  tagctrl_pkg::tagctrl_desc_t desc_q;
  logic                       valid_q;
  logic                       accept;
  logic                       is_read, is_write;

  assign desc_ready_o = !valid_q || desc_ready_i;
  assign accept       = desc_valid_i && desc_ready_o;

  // Error descriptors never touch the array
  assign is_read  = !desc_i.err && !desc_i.write;
  assign is_write = !desc_i.err && desc_i.write;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      tags_q  <= '0;
    end else begin
      if (desc_ready_o) begin
        valid_q <= desc_valid_i;
      end
      // Update lands on entry so any younger read sees it
      if (accept && is_write) begin
        tags_q[desc_i.tag_idx] <= desc_i.tag;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      desc_q            <= desc_i;
      desc_q.stored_tag <= is_read ? tags_q[desc_i.tag_idx] : 1'b0;
    end
  end

  assign desc_valid_o = valid_q;
  assign desc_o       = desc_q;

endmodule

// ==== verilog/tagctrl_top.sv ====
`timescale 1ns/1ps

module tagctrl_top (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // CPU side
  input  logic                          req_valid_i,
  input  tagctrl_pkg::tagctrl_req_t     req_i,
  output logic                          req_ready_o,
  output logic                          rsp_valid_o,
  output tagctrl_pkg::tagctrl_rsp_t     rsp_o,
  input  logic                          rsp_ready_i,
  // Memory side
  output logic                          mem_req_valid_o,
  output tagctrl_pkg::tagctrl_mem_req_t mem_req_o,
  input  logic                          mem_req_ready_i,
  input  logic                          mem_rsp_valid_i,
  input  tagctrl_pkg::tagctrl_mem_rsp_t mem_rsp_i
);
  // decode to tag store
  tagctrl_pkg::tagctrl_desc_t    dec_desc;
  logic                          dec_valid, dec_ready;

  // tag store to memory issue
  tagctrl_pkg::tagctrl_desc_t    ts_desc;
  logic                          ts_valid, ts_ready;

  // memory issue into the descriptor FIFO
  tagctrl_pkg::tagctrl_desc_t    push_desc;
  logic                          push_valid, push_ready;

  // FIFO heads toward the merge stage
  tagctrl_pkg::tagctrl_desc_t    head_desc;
  logic                          head_desc_valid, head_desc_ready;
  tagctrl_pkg::tagctrl_mem_rsp_t head_rdata;
  logic                          head_rdata_valid, head_rdata_ready;

  tagctrl_decode i_decode (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .desc_valid_o (dec_valid),
    .desc_o       (dec_desc),
    .desc_ready_i (dec_ready)
  );

  tagctrl_tag_store i_tag_store (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .desc_valid_i (dec_valid),
    .desc_i       (dec_desc),
    .desc_ready_o (dec_ready),
    .desc_valid_o (ts_valid),
    .desc_o       (ts_desc),
    .desc_ready_i (ts_ready)
  );

  tagctrl_mem_issue i_mem_issue (
    .desc_valid_i    (ts_valid),
    .desc_i          (ts_desc),
    .desc_ready_o    (ts_ready),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .fifo_valid_o    (push_valid),
    .fifo_desc_o     (push_desc),
    .fifo_ready_i    (push_ready)
  );

  // Bounds the number of requests in flight
  tagctrl_stream_fifo #(
    .payload_t (tagctrl_pkg::tagctrl_desc_t)
  ) i_desc_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (push_valid),
    .ready_o (push_ready),
    .data_i  (push_desc),
    .valid_o (head_desc_valid),
    .ready_i (head_desc_ready),
    .data_o  (head_desc)
  );

  // Pending reads never exceed the queued descriptors, so this one cannot overflow
  tagctrl_stream_fifo #(
    .payload_t (tagctrl_pkg::tagctrl_mem_rsp_t)
  ) i_rdata_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (mem_rsp_valid_i),
    .ready_o (),
    .data_i  (mem_rsp_i),
    .valid_o (head_rdata_valid),
    .ready_i (head_rdata_ready),
    .data_o  (head_rdata)
  );

  tagctrl_resp_merge i_resp_merge (
    .desc_valid_i (head_desc_valid),
    .desc_i       (head_desc),
    .desc_ready_o (head_desc_ready),
    .mem_valid_i  (head_rdata_valid),
    .mem_i        (head_rdata),
    .mem_ready_o  (head_rdata_ready),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .rsp_ready_i  (rsp_ready_i)
  );

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/tagctrl_pkg.sv
verilog/tagctrl_stream_fifo.sv
verilog/tagctrl_decode.sv
verilog/tagctrl_tag_store.sv
verilog/tagctrl_mem_issue.sv
verilog/tagctrl_resp_merge.sv
verilog/tagctrl_top.sv
testbench/tagctrl_chk.sv
testbench/tagctrl_tb.sv
